//--- msu_pkg.sv
package msu_pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////////////////////////

   // Stream word, iteration count and operand widths
   localparam int AXI_LEN  = 32;
   localparam int T_LEN    = 64;
   localparam int DAT_BITS = 64;

   // Fixed odd modulus, largest 64-bit prime
   localparam logic [DAT_BITS-1:0] MODULUS = 64'hFFFF_FFFF_FFFF_FFC5;

   // Words per job: t_start, t_final, sq_in in and t, result out
   localparam int AXI_IN_COUNT  = (2 * T_LEN + DAT_BITS) / AXI_LEN;
   localparam int AXI_OUT_COUNT = (T_LEN + DAT_BITS) / AXI_LEN;
   localparam int AXI_IN_BITS   = AXI_IN_COUNT * AXI_LEN;
   localparam int AXI_OUT_BITS  = AXI_OUT_COUNT * AXI_LEN;

   // Word counters and their final values
   localparam int IN_CNT_BITS  = $clog2(AXI_IN_COUNT);
   localparam int OUT_CNT_BITS = $clog2(AXI_OUT_COUNT);
   localparam logic [IN_CNT_BITS-1:0]  IN_LAST_WORD  = IN_CNT_BITS'(AXI_IN_COUNT - 1);
   localparam logic [OUT_CNT_BITS-1:0] OUT_LAST_WORD = OUT_CNT_BITS'(AXI_OUT_COUNT - 1);

   // Squarer: one multiplier bit per cycle plus the result cycle
   localparam int SQ_CYCLES   = DAT_BITS + 1;
   localparam int SQ_CNT_BITS = $clog2(DAT_BITS);
   localparam logic [SQ_CNT_BITS-1:0] SQ_LAST_BIT = SQ_CNT_BITS'(DAT_BITS - 1);

   // Accumulator holds 2*acc + operand, below three times the modulus
   localparam int SQ_ACC_BITS = DAT_BITS + 2;
   localparam logic [SQ_ACC_BITS-1:0] MOD_WIDE = {2'b00, MODULUS};

   //////////////////////////////////////////////////////////////////////
   // State encodings
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      rx_idle,
      rx_receive,
      rx_hold
   } rx_state_e;

   typedef enum logic [1:0] {
      iter_idle,
      iter_start,
      iter_compute,
      iter_finish
   } iter_state_e;

   typedef enum logic {
      tx_idle,
      tx_send
   } tx_state_e;

endpackage

//--- msu_rx.sv
`timescale 1ns/1ps

module msu_rx (
   input  logic                             clk,
   input  logic                             reset_1d,
   input  logic                             ap_start,
   input  logic                             s_axis_tvalid,
   output logic                             s_axis_tready,
   input  logic [msu_pkg::AXI_LEN-1:0]      s_axis_tdata,
   input  logic                             s_axis_tlast,
   input  logic                             job_done,
   output logic                             job_load,
   output logic [msu_pkg::T_LEN-1:0]        job_t_start,
   output logic [msu_pkg::T_LEN-1:0]        job_t_final,
   output logic [msu_pkg::DAT_BITS-1:0]     job_sq_in
);

   msu_pkg::rx_state_e                  state;
   logic [msu_pkg::IN_CNT_BITS-1:0]     word_cnt;
   logic [msu_pkg::AXI_IN_BITS-1:0]     axi_in;
   logic                                accept;
   logic                                last_word;

   // Job length is fixed, so tlast carries no information here
   assign s_axis_tready = (state == msu_pkg::rx_receive);
   assign accept        = s_axis_tvalid && s_axis_tready;
   assign last_word     = accept && (word_cnt == msu_pkg::IN_LAST_WORD);

   //////////////////////////////////////////////////////////////////////
   // Control
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset_1d) begin
         state    <= msu_pkg::rx_idle;
         word_cnt <= '0;
         job_load <= 1'b0;
      end else begin
         job_load <= last_word;
         case (state)
            msu_pkg::rx_idle: begin
               word_cnt <= '0;
               if (ap_start) begin
                  state <= msu_pkg::rx_receive;
               end
            end
            msu_pkg::rx_receive: begin
               if (last_word) begin
                  state <= msu_pkg::rx_hold;
               end else if (accept) begin
                  word_cnt <= word_cnt + 1'b1;
               end
            end
            // Blocked until the result has left the output side
            msu_pkg::rx_hold: begin
               if (job_done) begin
                  state <= msu_pkg::rx_idle;
               end
            end
            default: state <= msu_pkg::rx_idle;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Word capture
   //////////////////////////////////////////////////////////////////////

   // Least significant word first, so the first word ends up at bit 0
   always_ff @(posedge clk) begin
      if (accept) begin
         axi_in <= {s_axis_tdata, axi_in[msu_pkg::AXI_IN_BITS-1:msu_pkg::AXI_LEN]};
      end
   end

   assign job_t_start = axi_in[msu_pkg::T_LEN-1:0];
   assign job_t_final = axi_in[2*msu_pkg::T_LEN-1:msu_pkg::T_LEN];
   assign job_sq_in   = axi_in[msu_pkg::AXI_IN_BITS-1:2*msu_pkg::T_LEN];

endmodule

//--- modsqr_core.sv
`timescale 1ns/1ps

module modsqr_core (
   input  logic                             clk,
   input  logic                             reset_1d,
   input  logic                             sq_start,
   input  logic [msu_pkg::DAT_BITS-1:0]     sq_in,
   output logic [msu_pkg::DAT_BITS-1:0]     sq_out,
   output logic                             sq_valid
);

   logic [msu_pkg::DAT_BITS-1:0]        opnd;
   logic [msu_pkg::DAT_BITS-1:0]        mult;
   logic [msu_pkg::DAT_BITS-1:0]        acc;
   logic [msu_pkg::DAT_BITS-1:0]        addend;
   logic [msu_pkg::DAT_BITS-1:0]        acc_next;
   logic [msu_pkg::SQ_ACC_BITS-1:0]     acc_sum;
   logic [msu_pkg::SQ_ACC_BITS-1:0]     red1;
   logic [msu_pkg::SQ_ACC_BITS-1:0]     red2;
   logic [msu_pkg::SQ_CNT_BITS-1:0]     bit_cnt;
   logic                                busy;
   logic                                valid_q;

   //////////////////////////////////////////////////////////////////////
   // One interleaved step
   //////////////////////////////////////////////////////////////////////

   // Multiplier scanned from the top bit down
   assign addend  = mult[msu_pkg::DAT_BITS-1] ? opnd : '0;
   assign acc_sum = {1'b0, acc, 1'b0} + {2'b00, addend};

   // Sum is below 3*M, two conditional subtractions bring it under M
   assign red1     = (acc_sum >= msu_pkg::MOD_WIDE) ? acc_sum - msu_pkg::MOD_WIDE : acc_sum;
   assign red2     = (red1 >= msu_pkg::MOD_WIDE) ? red1 - msu_pkg::MOD_WIDE : red1;
   assign acc_next = red2[msu_pkg::DAT_BITS-1:0];

   //////////////////////////////////////////////////////////////////////
   // Sequencing
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset_1d) begin
         busy    <= 1'b0;
         valid_q <= 1'b0;
         bit_cnt <= '0;
      end else begin
         valid_q <= 1'b0;
         if (sq_start) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
         end else if (busy) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == msu_pkg::SQ_LAST_BIT) begin
               busy    <= 1'b0;
               valid_q <= 1'b1;
            end
         end
      end
   end

   // Operand enters both as multiplicand and multiplier
   always_ff @(posedge clk) begin
      if (sq_start) begin
         opnd <= sq_in;
         mult <= sq_in;
         acc  <= '0;
      end else if (busy) begin
         acc  <= acc_next;
         mult <= {mult[msu_pkg::DAT_BITS-2:0], 1'b0};
      end
   end

   assign sq_out   = acc;
   assign sq_valid = valid_q;

endmodule

//--- msu_iterate.sv
`timescale 1ns/1ps

module msu_iterate (
   input  logic                             clk,
   input  logic                             reset_1d,
   input  logic                             job_load,
   input  logic [msu_pkg::T_LEN-1:0]        job_t_start,
   input  logic [msu_pkg::T_LEN-1:0]        job_t_final,
   input  logic [msu_pkg::DAT_BITS-1:0]     job_sq_in,
   output logic                             res_valid,
   output logic [msu_pkg::T_LEN-1:0]        res_t,
   output logic [msu_pkg::DAT_BITS-1:0]     res_data
);

   msu_pkg::iter_state_e                state;
   logic [msu_pkg::T_LEN-1:0]           t_current;
   logic [msu_pkg::T_LEN-1:0]           t_final;
   logic [msu_pkg::DAT_BITS-1:0]        value;
   logic [msu_pkg::DAT_BITS-1:0]        sq_out;
   logic                                sq_start;
   logic                                sq_valid;
   logic                                more_steps;

   assign more_steps = (t_current != t_final);
   assign sq_start   = (state == msu_pkg::iter_start) && more_steps;

   //////////////////////////////////////////////////////////////////////
   // Iteration control
   //////////////////////////////////////////////////////////////////////

   // Each step costs one start cycle plus the squarer latency
   always_ff @(posedge clk) begin
      if (reset_1d) begin
         state <= msu_pkg::iter_idle;
      end else begin
         case (state)
            msu_pkg::iter_idle: begin
               if (job_load) begin
                  state <= msu_pkg::iter_start;
               end
            end
            msu_pkg::iter_start: begin
               state <= more_steps ? msu_pkg::iter_compute : msu_pkg::iter_finish;
            end
            msu_pkg::iter_compute: begin
               if (sq_valid) begin
                  state <= msu_pkg::iter_start;
               end
            end
            msu_pkg::iter_finish: state <= msu_pkg::iter_idle;
            default:              state <= msu_pkg::iter_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == msu_pkg::iter_idle) && job_load) begin
         t_current <= job_t_start;
         t_final   <= job_t_final;
         value     <= job_sq_in;
      end else if ((state == msu_pkg::iter_compute) && sq_valid) begin
         t_current <= t_current + 1'b1;
         value     <= sq_out;
      end
   end

   modsqr_core u_modsqr_core (
      .clk      (clk),
      .reset_1d (reset_1d),
      .sq_start (sq_start),
      .sq_in    (value),
      .sq_out   (sq_out),
      .sq_valid (sq_valid)
   );

   assign res_valid = (state == msu_pkg::iter_finish);
   assign res_t     = t_final;
   assign res_data  = value;

endmodule

//--- msu_tx.sv
`timescale 1ns/1ps

module msu_tx (
   input  logic                             clk,
   input  logic                             reset_1d,
   input  logic                             res_valid,
   input  logic [msu_pkg::T_LEN-1:0]        res_t,
   input  logic [msu_pkg::DAT_BITS-1:0]     res_data,
   output logic                             m_axis_tvalid,
   input  logic                             m_axis_tready,
   output logic [msu_pkg::AXI_LEN-1:0]      m_axis_tdata,
   output logic                             m_axis_tlast,
   output logic                             job_done
);

   msu_pkg::tx_state_e                  state;
   logic [msu_pkg::OUT_CNT_BITS-1:0]    beat_cnt;
   logic [msu_pkg::AXI_OUT_BITS-1:0]    out_sr;
   logic                                tx_busy;
   logic                                beat_ok;
   logic                                final_beat;

   assign tx_busy    = (state == msu_pkg::tx_send);
   assign final_beat = (beat_cnt == msu_pkg::OUT_LAST_WORD);
   assign beat_ok    = tx_busy && m_axis_tready;

   //////////////////////////////////////////////////////////////////////
   // Beat control
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset_1d) begin
         state    <= msu_pkg::tx_idle;
         beat_cnt <= '0;
      end else begin
         case (state)
            msu_pkg::tx_idle: begin
               beat_cnt <= '0;
               if (res_valid) begin
                  state <= msu_pkg::tx_send;
               end
            end
            msu_pkg::tx_send: begin
               if (beat_ok) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (final_beat) begin
                     state <= msu_pkg::tx_idle;
                  end
               end
            end
            default: state <= msu_pkg::tx_idle;
         endcase
      end
   end

   // Count goes out first, then the result, low word first
   always_ff @(posedge clk) begin
      if (!tx_busy && res_valid) begin
         out_sr <= {res_data, res_t};
      end else if (beat_ok) begin
         out_sr <= {{msu_pkg::AXI_LEN{1'b0}}, out_sr[msu_pkg::AXI_OUT_BITS-1:msu_pkg::AXI_LEN]};
      end
   end

   assign m_axis_tvalid = tx_busy;
   assign m_axis_tdata  = out_sr[msu_pkg::AXI_LEN-1:0];
   assign m_axis_tlast  = tx_busy && final_beat;
   // Done on the edge that takes the last beat
   assign job_done      = beat_ok && final_beat;

endmodule

//--- msu_top.sv
`timescale 1ns/1ps

module msu_top (
   input  logic                             clk,
   input  logic                             reset_1d,
   input  logic                             ap_start,
   input  logic                             s_axis_tvalid,
   output logic                             s_axis_tready,
   input  logic [msu_pkg::AXI_LEN-1:0]      s_axis_tdata,
   input  logic                             s_axis_tlast,
   output logic                             m_axis_tvalid,
   input  logic                             m_axis_tready,
   output logic [msu_pkg::AXI_LEN-1:0]      m_axis_tdata,
   output logic                             m_axis_tlast,
   output logic                             ap_done
);

   // Input side to processing
   logic                                job_load;
   logic [msu_pkg::T_LEN-1:0]           job_t_start;
   logic [msu_pkg::T_LEN-1:0]           job_t_final;
   logic [msu_pkg::DAT_BITS-1:0]        job_sq_in;

   // Processing to output side
   logic                                res_valid;
   logic [msu_pkg::T_LEN-1:0]           res_t;
   logic [msu_pkg::DAT_BITS-1:0]        res_data;

   logic                                job_done;

   msu_rx u_msu_rx (
      .clk           (clk),
      .reset_1d      (reset_1d),
      .ap_start      (ap_start),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tlast  (s_axis_tlast),
      .job_done      (job_done),
      .job_load      (job_load),
      .job_t_start   (job_t_start),
      .job_t_final   (job_t_final),
      .job_sq_in     (job_sq_in)
   );

   msu_iterate u_msu_iterate (
      .clk         (clk),
      .reset_1d    (reset_1d),
      .job_load    (job_load),
      .job_t_start (job_t_start),
      .job_t_final (job_t_final),
      .job_sq_in   (job_sq_in),
      .res_valid   (res_valid),
      .res_t       (res_t),
      .res_data    (res_data)
   );

   msu_tx u_msu_tx (
      .clk           (clk),
      .reset_1d      (reset_1d),
      .res_valid     (res_valid),
      .res_t         (res_t),
      .res_data      (res_data),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tlast  (m_axis_tlast),
      .job_done      (job_done)
   );

   assign ap_done = job_done;

endmodule

//--- msu_assertions.sv
`timescale 1ns/1ps

module msu_assertions (
   input logic                          clk,
   input logic                          reset_1d,
   input logic                          s_axis_tvalid,
   input logic                          s_axis_tready,
   input logic                          s_axis_tlast,
   input logic                          m_axis_tvalid,
   input logic                          m_axis_tready,
   input logic [msu_pkg::AXI_LEN-1:0]   m_axis_tdata,
   input logic                          m_axis_tlast,
   input logic                          ap_done
);

   logic [msu_pkg::IN_CNT_BITS-1:0] in_cnt;

   // Position of the next accepted input word within the job
   always_ff @(posedge clk) begin
      if (reset_1d) begin
         in_cnt <= '0;
      end else if (s_axis_tvalid && s_axis_tready) begin
         in_cnt <= (in_cnt == msu_pkg::IN_LAST_WORD) ? '0 : in_cnt + 1'b1;
      end
   end

   a_out_stall_stable: assert property (@(posedge clk) disable iff (reset_1d)
      m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata))
      else $error("Stalled output beat changed before it was accepted");

   a_done_with_last: assert property (@(posedge clk) disable iff (reset_1d)
      ap_done == (m_axis_tvalid && m_axis_tready && m_axis_tlast))
      else $error("ap_done and the last output beat are not aligned");

   a_rx_tx_exclusive: assert property (@(posedge clk) disable iff (reset_1d)
      !(s_axis_tready && m_axis_tvalid))
      else $error("Input ready while output is valid");

   a_in_last_sixth: assert property (@(posedge clk) disable iff (reset_1d)
      s_axis_tvalid && s_axis_tready && s_axis_tlast |-> in_cnt == msu_pkg::IN_LAST_WORD)
      else $error("Input tlast on a word other than the sixth");

endmodule

bind msu_top msu_assertions u_msu_assertions (
   .clk           (clk),
   .reset_1d      (reset_1d),
   .s_axis_tvalid (s_axis_tvalid),
   .s_axis_tready (s_axis_tready),
   .s_axis_tlast  (s_axis_tlast),
   .m_axis_tvalid (m_axis_tvalid),
   .m_axis_tready (m_axis_tready),
   .m_axis_tdata  (m_axis_tdata),
   .m_axis_tlast  (m_axis_tlast),
   .ap_done       (ap_done)
);

//--- tb_msu.sv
`timescale 1ns/1ps

module tb_msu;

   logic                              clk;
   logic                              reset_1d;
   logic                              ap_start;
   logic                              s_axis_tvalid;
   logic                              s_axis_tready;
   logic [msu_pkg::AXI_LEN-1:0]       s_axis_tdata;
   logic                              s_axis_tlast;
   logic                              m_axis_tvalid;
   logic                              m_axis_tready;
   logic [msu_pkg::AXI_LEN-1:0]       m_axis_tdata;
   logic                              m_axis_tlast;
   logic                              ap_done;

   int                                seed    = 32'h4da8;
   int                                chk_cnt = 0;
   int                                err_cnt = 0;

   msu_top u_dut (
      .clk           (clk),
      .reset_1d      (reset_1d),
      .ap_start      (ap_start),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tlast  (s_axis_tlast),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tlast  (m_axis_tlast),
      .ap_done       (ap_done)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Reference model and compare tasks
   //////////////////////////////////////////////////////////////////////

   // Repeated squaring with a full 128-bit product
   function automatic logic [msu_pkg::DAT_BITS-1:0] ref_square(
      input logic [msu_pkg::DAT_BITS-1:0] x,
      input logic [msu_pkg::T_LEN-1:0]    steps
   );
      logic [2*msu_pkg::DAT_BITS-1:0] wide;
      logic [msu_pkg::DAT_BITS-1:0]   val;
      logic [msu_pkg::T_LEN-1:0]      i;
      val = x;
      for (i = '0; i < steps; i = i + 1'b1) begin
         wide = {{msu_pkg::DAT_BITS{1'b0}}, val} * {{msu_pkg::DAT_BITS{1'b0}}, val};
         wide = wide % {{msu_pkg::DAT_BITS{1'b0}}, msu_pkg::MODULUS};
         val  = wide[msu_pkg::DAT_BITS-1:0];
      end
      return val;
   endfunction

   task automatic check_count(input string name, input logic [msu_pkg::T_LEN-1:0] got,
                              input logic [msu_pkg::T_LEN-1:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("FAIL %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_data(input string name, input logic [msu_pkg::DAT_BITS-1:0] got,
                             input logic [msu_pkg::DAT_BITS-1:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("FAIL %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_word(input string name, input logic [msu_pkg::AXI_LEN-1:0] got,
                             input logic [msu_pkg::AXI_LEN-1:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("FAIL %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("FAIL %s got %h expected %h", name, got, exp);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////

   // Reset seen by the given number of rising edges
   task automatic apply_reset(input int cycles);
      reset_1d = 1'b1;
      repeat (cycles) @(posedge clk);
      @(negedge clk);
      reset_1d = 1'b0;
   endtask

   // Start pulse, then six words low word first
   task automatic send_job(input logic [msu_pkg::T_LEN-1:0] t_start,
                           input logic [msu_pkg::T_LEN-1:0] t_final,
                           input logic [msu_pkg::DAT_BITS-1:0] x);
      logic [msu_pkg::AXI_IN_BITS-1:0] words;
      int                              i;
      words = {x, t_final, t_start};
      @(negedge clk);
      ap_start = 1'b1;
      @(negedge clk);
      ap_start = 1'b0;
      // Ready one cycle after the start pulse
      check_flag("s_axis_tready", s_axis_tready, 1'b1);
      for (i = 0; i < msu_pkg::AXI_IN_COUNT; i++) begin
         s_axis_tvalid = 1'b1;
         s_axis_tdata  = words[i*msu_pkg::AXI_LEN +: msu_pkg::AXI_LEN];
         s_axis_tlast  = (i == msu_pkg::AXI_IN_COUNT - 1);
         while (!s_axis_tready) @(negedge clk);
         @(negedge clk);
      end
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      s_axis_tdata  = '0;
   endtask

   // Collects four beats; optional extra start pulse while the job is busy
   task automatic recv_result(input logic [msu_pkg::T_LEN-1:0] exp_t,
                              input logic [msu_pkg::DAT_BITS-1:0] exp_d,
                              input bit rand_ready, input bit poke_start);
      logic [msu_pkg::AXI_OUT_BITS-1:0] exp_all;
      logic [msu_pkg::AXI_OUT_BITS-1:0] got_all;
      int                               beat;
      int                               cyc;
      int                               rnd;
      exp_all = {exp_d, exp_t};
      got_all = '0;
      beat    = 0;
      cyc     = 0;
      while (beat < msu_pkg::AXI_OUT_COUNT) begin
         @(negedge clk);
         rnd           = $random(seed);
         ap_start      = poke_start && (cyc == 2);
         m_axis_tready = rand_ready ? rnd[0] : 1'b1;
         #1;
         cyc++;
         if (s_axis_tready) begin
            err_cnt++;
            $display("Input side accepted words while a job was still in progress");
         end
         if (m_axis_tvalid && m_axis_tready) begin
            check_word("m_axis_tdata", m_axis_tdata,
                       exp_all[beat*msu_pkg::AXI_LEN +: msu_pkg::AXI_LEN]);
            check_flag("m_axis_tlast", m_axis_tlast, beat == msu_pkg::AXI_OUT_COUNT - 1);
            check_flag("ap_done", ap_done, beat == msu_pkg::AXI_OUT_COUNT - 1);
            got_all[beat*msu_pkg::AXI_LEN +: msu_pkg::AXI_LEN] = m_axis_tdata;
            beat++;
         end else begin
            check_flag("ap_done", ap_done, 1'b0);
         end
      end
      @(negedge clk);
      ap_start      = 1'b0;
      m_axis_tready = 1'b0;
      check_count("res_t", got_all[msu_pkg::T_LEN-1:0], exp_t);
      check_data("res_data", got_all[msu_pkg::AXI_OUT_BITS-1:msu_pkg::T_LEN], exp_d);
   endtask

   task automatic run_job(input logic [msu_pkg::T_LEN-1:0] t_start,
                          input logic [msu_pkg::T_LEN-1:0] t_final,
                          input logic [msu_pkg::DAT_BITS-1:0] x,
                          input bit rand_ready, input bit poke_start);
      send_job(t_start, t_final, x);
      recv_result(t_final, ref_square(x, t_final - t_start), rand_ready, poke_start);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic zero_iteration_job();
      run_job(64'd7, 64'd7, 64'hDEAD_BEEF_0BAD_F00D, 1'b0, 1'b0);
   endtask

   task automatic short_squaring_runs();
      run_job(64'd0, 64'd1, 64'h0123_4567_89AB_CDEF, 1'b0, 1'b0);
      run_job(64'h1_0000_0005, 64'h1_0000_000A, 64'hFEDC_BA98_7654_3210, 1'b0, 1'b0);
   endtask

   task automatic operand_extremes();
      run_job(64'd10, 64'd13, msu_pkg::MODULUS - 64'd2, 1'b0, 1'b0);
      run_job(64'd0, 64'd4, 64'd1, 1'b0, 1'b0);
   endtask

   task automatic output_backpressure();
      run_job(64'd100, 64'd106, 64'h8000_0000_0000_0001, 1'b1, 1'b0);
   endtask

   // Stray start pulse during the first job must be ignored
   task automatic back_to_back_jobs();
      run_job(64'd0, 64'd2, 64'hA5A5_A5A5_5A5A_5A5A, 1'b0, 1'b1);
      run_job(64'd2, 64'd5, 64'h3C3C_C3C3_0F0F_F0F0, 1'b1, 1'b0);
   endtask

   task automatic reset_mid_job();
      int wait_cyc;
      send_job(64'd0, 64'd20, 64'h7777_1111_2222_3333);
      repeat (30) @(negedge clk);
      apply_reset(8);
      check_flag("s_axis_tready", s_axis_tready, 1'b0);
      check_flag("m_axis_tvalid", m_axis_tvalid, 1'b0);
      check_flag("ap_done", ap_done, 1'b0);
      // Abandoned job would have reached the output within its full length
      m_axis_tready = 1'b1;
      wait_cyc      = 0;
      while (wait_cyc < 20 * (msu_pkg::SQ_CYCLES + 1) && !m_axis_tvalid && !ap_done) begin
         @(negedge clk);
         wait_cyc++;
      end
      check_flag("m_axis_tvalid", m_axis_tvalid, 1'b0);
      check_flag("ap_done", ap_done, 1'b0);
      m_axis_tready = 1'b0;
      run_job(64'd3, 64'd5, 64'h0000_0001_0000_0003, 1'b0, 1'b0);
   endtask

   // Limit from all requested squarings plus a margin per job
   initial begin
      int job_steps [10];
      int limit_cycles;
      int j;
      job_steps    = '{0, 1, 5, 3, 4, 6, 2, 3, 20, 2};
      limit_cycles = 0;
      for (j = 0; j < 10; j++) begin
         limit_cycles += job_steps[j] * (msu_pkg::SQ_CYCLES + 1) + 100;
      end
      #(limit_cycles * 100);
      $display("Timeout after %0d cycles, the tests did not finish", limit_cycles);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      ap_start      = 1'b0;
      s_axis_tvalid = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tlast  = 1'b0;
      m_axis_tready = 1'b0;
      apply_reset(8);
      zero_iteration_job();
      short_squaring_runs();
      operand_extremes();
      output_backpressure();
      back_to_back_jobs();
      reset_mid_job();
      $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- sim.f
msu_pkg.sv
msu_rx.sv
modsqr_core.sv
msu_iterate.sv
msu_tx.sv
msu_top.sv
msu_assertions.sv
tb_msu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_msu
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
